// ==== source/id_queue_cfg.svh ====
// Size settings of the ID queue, included by its package and by the testbench
`ifndef ID_QUEUE_CFG_SVH
`define ID_QUEUE_CFG_SVH

// Number of bits in an ID
// Every ID value may have its own FIFO chain in the queue
`define ID_QUEUE_ID_WIDTH 2

// Number of bits in one stored element
// The exists mask has the same width
`define ID_QUEUE_DATA_WIDTH 8

// Total number of element slots, shared by all IDs
// A push is refused once all of them are in use
`define ID_QUEUE_CAPACITY 8

`endif

// ==== source/id_queue_pkg.sv ====
// Types and derived sizes shared by all ID queue modules, referenced by scoped names
`include "id_queue_cfg.svh"
`default_nettype none

package id_queue_pkg;

    // Number of element slots in the linked data store
    localparam int unsigned capacity = `ID_QUEUE_CAPACITY;

    // Number of distinct IDs
    localparam int unsigned n_ids = 2 ** `ID_QUEUE_ID_WIDTH;

    // The table never needs more entries than there are IDs or slots
    localparam int unsigned ht_capacity = (n_ids <= capacity) ? n_ids : capacity;

    // Index widths, kept at one bit or more for tiny configurations
    localparam int unsigned ld_idx_width = (capacity > 1) ? $clog2(capacity) : 1;
    localparam int unsigned ht_idx_width = (ht_capacity > 1) ? $clog2(ht_capacity) : 1;

    typedef logic [`ID_QUEUE_ID_WIDTH-1:0] id_t;
    typedef logic [`ID_QUEUE_DATA_WIDTH-1:0] data_t;
    typedef logic [ld_idx_width-1:0] ld_idx_t;
    typedef logic [ht_idx_width-1:0] ht_idx_t;

    // One head-tail entry: the ID and the slots of its oldest and newest element
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } head_tail_t;

    // One element slot with its link to the next younger element of the same ID
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } linked_data_t;

endpackage

`default_nettype wire

// ==== source/lzc.sv ====
// Lowest-set-bit finder, used for free-slot, free-entry and exists-match searches
`default_nettype none

module lzc #(
    parameter int unsigned WIDTH = 4,
    localparam int unsigned cnt_width = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  wire logic [WIDTH-1:0]     in_i,
    output logic      [cnt_width-1:0] cnt_o,
    output logic                      empty_o
);

    // Scan from the top down so that the lowest set bit is written last
    // An all-zero input leaves the index at zero
    always_comb begin
        cnt_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (in_i[i]) begin
                cnt_o = cnt_width'(i);
            end
        end
    end

    // Flags that no bit is set, the index is meaningless then
    assign empty_o = ~|in_i;

endmodule

`default_nettype wire

// ==== source/head_tail_table.sv ====
// Head-tail table of the ID queue with its controller interface; maps live IDs to slots
`default_nettype none

interface ht_if;
    // Lookup request from the controller
    id_queue_pkg::id_t          lookup_id;
    logic                       lookup_valid;
    // Whole-entry write, applied on the next rising edge
    logic                       wr_en;
    id_queue_pkg::ht_idx_t      wr_idx;
    id_queue_pkg::head_tail_t   wr_entry;
    // Lookup result and free-entry search
    logic                       hit;
    id_queue_pkg::ht_idx_t      match_idx;
    id_queue_pkg::head_tail_t   match_entry;
    id_queue_pkg::ht_idx_t      free_idx;
    logic                       free_valid;

    modport tbl (
        input  lookup_id, lookup_valid, wr_en, wr_idx, wr_entry,
        output hit, match_idx, match_entry, free_idx, free_valid
    );

    modport ctrl (
        output lookup_id, lookup_valid, wr_en, wr_idx, wr_entry,
        input  hit, match_idx, match_entry, free_idx, free_valid
    );
endinterface

module head_tail_table (
    input wire logic clk_i,
    input wire logic rst_ni,
    ht_if.tbl        ht
);

    localparam int unsigned n_entries = id_queue_pkg::ht_capacity;

    // Value of an entry that holds no ID
    localparam id_queue_pkg::head_tail_t entry_free = '{
        id:   '0,
        head: '0,
        tail: '0,
        free: 1'b1
    };

    id_queue_pkg::head_tail_t [n_entries-1:0] entry_q;

    logic [n_entries-1:0]  id_match;
    logic [n_entries-1:0]  entry_is_free;
    id_queue_pkg::ht_idx_t match_idx;
    logic                  no_free;

    // Compare the lookup ID against every live entry
    for (genvar i = 0; i < n_entries; i++) begin : gen_match
        assign id_match[i] = ht.lookup_valid && !entry_q[i].free &&
                             (entry_q[i].id == ht.lookup_id);
        assign entry_is_free[i] = entry_q[i].free;
    end

    assign ht.hit = |id_match;

    // One-hot to binary, OR of the indices of all set bits
    // Only one bit can be set since each ID owns at most one entry
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < n_entries; i++) begin
            if (id_match[i]) begin
                match_idx = match_idx | id_queue_pkg::ht_idx_t'(i);
            end
        end
    end

    assign ht.match_idx   = match_idx;
    assign ht.match_entry = entry_q[match_idx];

    // Lowest free entry, taken when a push brings a new ID
    lzc #(
        .WIDTH (n_entries)
    ) u_free_lzc (
        .in_i    (entry_is_free),
        .cnt_o   (ht.free_idx),
        .empty_o (no_free)
    );

    assign ht.free_valid = !no_free;

    // Entries start out free and are replaced whole on a write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < n_entries; i++) begin
                entry_q[i] <= entry_free;
            end
        end else if (ht.wr_en) begin
            entry_q[ht.wr_idx] <= ht.wr_entry;
        end
    end

    // Two live entries with the same ID would split one FIFO chain
    a_unique_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(id_match));

endmodule

`default_nettype wire

// ==== source/linked_data_store.sv ====
// Linked element store of the ID queue with its controller interface and the exists search
`default_nettype none

interface ld_if;
    // New element, written into the lowest free slot
    logic                    alloc_en;
    id_queue_pkg::data_t     alloc_data;
    // Link of the old tail to the new slot
    logic                    link_en;
    id_queue_pkg::ld_idx_t   link_idx;
    id_queue_pkg::ld_idx_t   link_next;
    // Slot release on a pop
    logic                    release_en;
    id_queue_pkg::ld_idx_t   release_idx;
    // Read port for the head of a chain
    id_queue_pkg::ld_idx_t   rd_idx;
    id_queue_pkg::data_t     rd_data;
    id_queue_pkg::ld_idx_t   rd_next;
    // Allocation status
    id_queue_pkg::ld_idx_t   free_idx;
    logic                    full;

    modport store (
        input  alloc_en, alloc_data, link_en, link_idx, link_next,
        input  release_en, release_idx, rd_idx,
        output free_idx, full, rd_data, rd_next
    );

    modport ctrl (
        output alloc_en, alloc_data, link_en, link_idx, link_next,
        output release_en, release_idx, rd_idx,
        input  free_idx, full, rd_data, rd_next
    );
endinterface

module linked_data_store (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    ld_if.store                       ld,
    input  wire id_queue_pkg::data_t  exists_data_i,
    input  wire id_queue_pkg::data_t  exists_mask_i,
    input  wire logic                 exists_req_i,
    output logic                      exists_o,
    output logic                      exists_gnt_o,
    output id_queue_pkg::data_t       exists_data_o
);

    localparam int unsigned n_slots = id_queue_pkg::capacity;

    // Value of an unused slot
    localparam id_queue_pkg::linked_data_t slot_free = '{
        data: '0,
        next: '0,
        free: 1'b1
    };

    id_queue_pkg::linked_data_t [n_slots-1:0] slot_q;

    logic [n_slots-1:0]    slot_is_free;
    logic [n_slots-1:0]    exists_match;
    id_queue_pkg::ld_idx_t exists_idx;
    logic                  exists_none;
    logic                  no_free;

    for (genvar i = 0; i < n_slots; i++) begin : gen_slot
        assign slot_is_free[i] = slot_q[i].free;
        // A bit takes part in the compare only where the mask is set
        // Free slots are never reported as a match
        assign exists_match[i] = !slot_q[i].free &&
            (((slot_q[i].data ^ exists_data_i) & exists_mask_i) == '0);
    end

    // A push always fills the lowest free slot
    lzc #(
        .WIDTH (n_slots)
    ) u_free_lzc (
        .in_i    (slot_is_free),
        .cnt_o   (ld.free_idx),
        .empty_o (no_free)
    );

    assign ld.full = no_free;

    // Head read for the controller, used for output data and head advance
    assign ld.rd_data = slot_q[ld.rd_idx].data;
    assign ld.rd_next = slot_q[ld.rd_idx].next;

    // The exists search reports the lowest matching slot
    lzc #(
        .WIDTH (n_slots)
    ) u_exists_lzc (
        .in_i    (exists_match),
        .cnt_o   (exists_idx),
        .empty_o (exists_none)
    );

    assign exists_gnt_o  = exists_req_i;
    assign exists_o      = exists_req_i && !exists_none;
    assign exists_data_o = slot_q[exists_idx].data;

    // Allocation and link always hit different slots, the link goes to a live tail
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < n_slots; i++) begin
                slot_q[i] <= slot_free;
            end
        end else begin
            if (ld.alloc_en) begin
                slot_q[ld.free_idx] <= '{data: ld.alloc_data, next: '0, free: 1'b0};
            end
            if (ld.link_en) begin
                slot_q[ld.link_idx].next <= ld.link_next;
            end
            if (ld.release_en) begin
                slot_q[ld.release_idx].free <= 1'b1;
            end
        end
    end

    // A pop must release a slot that the table still points at
    a_release_live : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld.release_en |-> !slot_q[ld.release_idx].free);

    // The controller must respect back-pressure
    a_alloc_not_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ld.alloc_en |-> !ld.full);

endmodule

`default_nettype wire

// ==== source/queue_control.sv ====
// Controller of the ID queue; arbitrates push against output access and drives all updates
`default_nettype none

module queue_control (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire id_queue_pkg::id_t    inp_id_i,
    input  wire id_queue_pkg::data_t  inp_data_i,
    input  wire logic                 inp_req_i,
    output logic                      inp_gnt_o,
    input  wire id_queue_pkg::id_t    oup_id_i,
    input  wire logic                 oup_pop_i,
    input  wire logic                 oup_req_i,
    output id_queue_pkg::data_t       oup_data_o,
    output logic                      oup_data_valid_o,
    output logic                      oup_gnt_o,
    ht_if.ctrl                        ht,
    ld_if.ctrl                        ld
);

    logic push;

    // Pushes are accepted while a slot is free and win over output access
    assign inp_gnt_o = !ld.full;
    assign push      = inp_req_i && inp_gnt_o;

    // Output data is the head of the looked-up chain
    assign oup_data_o = ld.rd_data;

    always_comb begin
        // The table looks up whichever ID the granted access uses
        ht.lookup_id    = push ? inp_id_i : oup_id_i;
        ht.lookup_valid = push || oup_req_i;
        ht.wr_en        = 1'b0;
        ht.wr_idx       = ht.match_idx;
        ht.wr_entry     = ht.match_entry;
        ld.alloc_en     = 1'b0;
        ld.alloc_data   = inp_data_i;
        ld.link_en      = 1'b0;
        ld.link_idx     = ht.match_entry.tail;
        ld.link_next    = ld.free_idx;
        ld.release_en   = 1'b0;
        ld.release_idx  = ht.match_entry.head;
        ld.rd_idx       = ht.match_entry.head;
        oup_gnt_o        = 1'b0;
        oup_data_valid_o = 1'b0;
        if (push) begin
            ld.alloc_en = 1'b1;
            ht.wr_en    = 1'b1;
            if (!ht.hit) begin
                // First element of this ID opens a fresh entry
                ht.wr_idx   = ht.free_idx;
                ht.wr_entry = '{id: inp_id_i, head: ld.free_idx, tail: ld.free_idx, free: 1'b0};
            end else begin
                // Append behind the current tail
                ld.link_en       = 1'b1;
                ht.wr_entry.tail = ld.free_idx;
            end
        end else if (oup_req_i) begin
            oup_gnt_o        = 1'b1;
            oup_data_valid_o = ht.hit;
            if (ht.hit && oup_pop_i) begin
                ld.release_en = 1'b1;
                ht.wr_en      = 1'b1;
                if (ht.match_entry.head == ht.match_entry.tail) begin
                    // Last element of this ID, the entry goes back to the free pool
                    ht.wr_entry.free = 1'b1;
                end else begin
                    ht.wr_entry.head = ld.rd_next;
                end
            end
        end
    end

    // A new ID always finds room since entries never outnumber IDs or slots
    a_ht_room : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push && !ht.hit) |-> ht.free_valid);

endmodule

`default_nettype wire

// ==== source/id_queue.sv ====
// Top level of the ID queue; connects table, store and controller to plain ports
`default_nettype none

module id_queue (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,

    // Push port
    input  wire id_queue_pkg::id_t    inp_id_i,
    input  wire id_queue_pkg::data_t  inp_data_i,
    input  wire logic                 inp_req_i,
    output logic                      inp_gnt_o,

    // Masked search over all stored elements
    input  wire id_queue_pkg::data_t  exists_data_i,
    input  wire id_queue_pkg::data_t  exists_mask_i,
    input  wire logic                 exists_req_i,
    output id_queue_pkg::data_t       exists_data_o,
    output logic                      exists_o,
    output logic                      exists_gnt_o,

    // Read or pop port
    input  wire id_queue_pkg::id_t    oup_id_i,
    input  wire logic                 oup_pop_i,
    input  wire logic                 oup_req_i,
    output id_queue_pkg::data_t       oup_data_o,
    output logic                      oup_data_valid_o,
    output logic                      oup_gnt_o
);

    ht_if ht_bus ();
    ld_if ld_bus ();

    head_tail_table u_head_tail_table (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .ht     (ht_bus.tbl)
    );

    // The exists search lives entirely in the store
    linked_data_store u_linked_data_store (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ld            (ld_bus.store),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .exists_req_i  (exists_req_i),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o),
        .exists_data_o (exists_data_o)
    );

    queue_control u_queue_control (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .inp_req_i        (inp_req_i),
        .inp_gnt_o        (inp_gnt_o),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .oup_req_i        (oup_req_i),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .oup_gnt_o        (oup_gnt_o),
        .ht               (ht_bus.ctrl),
        .ld               (ld_bus.ctrl)
    );

endmodule

`default_nettype wire

// ==== test/tb_id_queue.sv ====
// Self-checking testbench of the ID queue; replays the stimulus file against the DUT
`default_nettype none
`include "id_queue_cfg.svh"

module tb_id_queue;

    localparam int clk_half      = 10;
    localparam int reset_timeout = 20;
    localparam int max_lines     = 400;

    logic clk_i;
    logic rst_ni;

    // Push port
    logic [`ID_QUEUE_ID_WIDTH-1:0]   inp_id;
    logic [`ID_QUEUE_DATA_WIDTH-1:0] inp_data;
    logic                            inp_req;
    logic                            inp_gnt;

    // Exists search port
    logic [`ID_QUEUE_DATA_WIDTH-1:0] exists_data;
    logic [`ID_QUEUE_DATA_WIDTH-1:0] exists_mask;
    logic                            exists_req;
    logic [`ID_QUEUE_DATA_WIDTH-1:0] exists_data_out;
    logic                            exists_res;
    logic                            exists_gnt;

    // Read or pop port
    logic [`ID_QUEUE_ID_WIDTH-1:0]   oup_id;
    logic                            oup_pop;
    logic                            oup_req;
    logic [`ID_QUEUE_DATA_WIDTH-1:0] oup_data;
    logic                            oup_valid;
    logic                            oup_gnt;

    // Counters for the closing line
    int n_ops;
    int n_mismatch;
    int n_other;

    id_queue uut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_id_i         (inp_id),
        .inp_data_i       (inp_data),
        .inp_req_i        (inp_req),
        .inp_gnt_o        (inp_gnt),
        .exists_data_i    (exists_data),
        .exists_mask_i    (exists_mask),
        .exists_req_i     (exists_req),
        .exists_data_o    (exists_data_out),
        .exists_o         (exists_res),
        .exists_gnt_o     (exists_gnt),
        .oup_id_i         (oup_id),
        .oup_pop_i        (oup_pop),
        .oup_req_i        (oup_req),
        .oup_data_o       (oup_data),
        .oup_data_valid_o (oup_valid),
        .oup_gnt_o        (oup_gnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clk_half) clk_i = ~clk_i;
    end

    // All requests low, so the cycle is idle
    task automatic clear_inputs();
        inp_id      = '0;
        inp_data    = '0;
        inp_req     = 1'b0;
        exists_data = '0;
        exists_mask = '0;
        exists_req  = 1'b0;
        oup_id      = '0;
        oup_pop     = 1'b0;
        oup_req     = 1'b0;
    endtask

    task automatic report_mismatch(string name, string what, logic [31:0] exp,
                                   logic [31:0] act);
        $display("error %s: %s expected %0h actual %0h", name, what, exp, act);
        n_mismatch++;
    endtask

    // Sets the DUT inputs for one operation of the file
    task automatic drive_op(string name, string op, logic [`ID_QUEUE_ID_WIDTH-1:0] id,
                            logic [`ID_QUEUE_DATA_WIDTH-1:0] data,
                            logic [`ID_QUEUE_DATA_WIDTH-1:0] mask);
        clear_inputs();
        if (op == "push" || op == "both") begin
            inp_req  = 1'b1;
            inp_id   = id;
            inp_data = data;
        end
        // A combined request also reads the same ID, which loses against the push
        if (op == "read" || op == "pop" || op == "both") begin
            oup_req = 1'b1;
            oup_id  = id;
            oup_pop = (op == "pop");
        end
        if (op == "exists") begin
            exists_req  = 1'b1;
            exists_data = data;
            exists_mask = mask;
        end
        if (op != "push" && op != "both" && op != "read" && op != "pop" &&
            op != "exists" && op != "idle") begin
            $display("operation %s of step %s is not known", op, name);
            n_other++;
        end
    endtask

    // Compares the combinational answer of the DUT before the next rising edge
    task automatic check_op(string name, string op, logic e_gnt, logic e_valid,
                            logic [`ID_QUEUE_DATA_WIDTH-1:0] e_data, logic e_ex,
                            logic [`ID_QUEUE_DATA_WIDTH-1:0] e_exdata);
        if (op == "push" || op == "idle") begin
            if (inp_gnt !== e_gnt) report_mismatch(name, "inp_gnt_o", e_gnt, inp_gnt);
        end else if (op == "both") begin
            if (oup_gnt !== e_gnt) report_mismatch(name, "oup_gnt_o", e_gnt, oup_gnt);
        end else if (op == "read" || op == "pop") begin
            if (oup_gnt !== e_gnt) report_mismatch(name, "oup_gnt_o", e_gnt, oup_gnt);
            if (oup_valid !== e_valid) begin
                report_mismatch(name, "oup_data_valid_o", e_valid, oup_valid);
            end
            // Data only means something for a present ID
            if (e_valid && oup_data !== e_data) begin
                report_mismatch(name, "oup_data_o", e_data, oup_data);
            end
        end else if (op == "exists") begin
            if (exists_gnt !== e_gnt) report_mismatch(name, "exists_gnt_o", e_gnt, exists_gnt);
            if (exists_res !== e_ex) report_mismatch(name, "exists_o", e_ex, exists_res);
            if (e_ex && exists_data_out !== e_exdata) begin
                report_mismatch(name, "exists_data_o", e_exdata, exists_data_out);
            end
        end
    endtask

    // Reads the file line by line, one operation per clock cycle
    task automatic run_stimulus();
        int                              fd;
        int                              n;
        int                              line_no;
        bit                              done;
        string                           line;
        string                           name;
        string                           op;
        logic [`ID_QUEUE_ID_WIDTH-1:0]   id;
        logic [`ID_QUEUE_DATA_WIDTH-1:0] data;
        logic [`ID_QUEUE_DATA_WIDTH-1:0] mask;
        logic                            e_gnt;
        logic                            e_valid;
        logic [`ID_QUEUE_DATA_WIDTH-1:0] e_data;
        logic                            e_ex;
        logic [`ID_QUEUE_DATA_WIDTH-1:0] e_exdata;
        fd = $fopen("test/id_queue_stimulus.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file test/id_queue_stimulus.txt could not be opened");
            n_other++;
            return;
        end
        done    = 1'b0;
        line_no = 0;
        while (!done && line_no < max_lines) begin
            line_no++;
            if ($fgets(line, fd) == 0) begin
                $display("the stimulus file ended after %0d lines without its end line",
                         line_no - 1);
                n_other++;
                done = 1'b1;
            end else if (line.len() > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", name, op, id, data,
                            mask, e_gnt, e_valid, e_data, e_ex, e_exdata);
                if (n != 10) begin
                    $display("line %0d of the stimulus file has %0d fields instead of 10",
                             line_no, n);
                    n_other++;
                end else if (op == "end") begin
                    done = 1'b1;
                end else begin
                    @(negedge clk_i);
                    drive_op(name, op, id, data, mask);
                    #(clk_half / 2);
                    check_op(name, op, e_gnt, e_valid, e_data, e_ex, e_exdata);
                    n_ops++;
                end
            end
        end
        if (!done) begin
            $display("no end line found within %0d lines of the stimulus file", max_lines);
            n_other++;
        end
        $fclose(fd);
        @(negedge clk_i);
        clear_inputs();
    endtask

    task automatic finish_run();
        $display("%0d operations, %0d value errors, %0d other errors",
                 n_ops, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        int wait_cycles;
        n_ops      = 0;
        n_mismatch = 0;
        n_other    = 0;
        rst_ni     = 1'b0;
        clear_inputs();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // The queue is ready once it grants pushes
        wait_cycles = 0;
        while (inp_gnt !== 1'b1 && wait_cycles < reset_timeout) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (inp_gnt !== 1'b1) begin
            $display("timeout, inp_gnt_o did not rise within %0d cycles after reset",
                     reset_timeout);
            n_other++;
        end else begin
            run_stimulus();
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== test/id_queue_stimulus.txt ====
# Columns: name op id data mask, then expected gnt valid data exists exists_data, all hex
# gnt is inp_gnt_o for push and idle, oup_gnt_o for read, pop and both, exists_gnt_o for exists
rst_gnt      idle   0 00 00  1 0 00 0 00
rst_read     read   2 00 00  1 0 00 0 00
rst_exists   exists 0 00 00  1 0 00 0 00
fifo_push_a  push   0 a1 00  1 0 00 0 00
fifo_push_b  push   1 b1 00  1 0 00 0 00
fifo_push_c  push   0 a2 00  1 0 00 0 00
fifo_pop_a   pop    0 00 00  1 1 a1 0 00
fifo_read_b  read   1 00 00  1 1 b1 0 00
fifo_pop_c   pop    0 00 00  1 1 a2 0 00
fifo_empty   read   0 00 00  1 0 00 0 00
peek_push    push   2 c5 00  1 0 00 0 00
peek_read    read   2 00 00  1 1 c5 0 00
peek_again   read   2 00 00  1 1 c5 0 00
peek_pop     pop    2 00 00  1 1 c5 0 00
peek_gone    read   2 00 00  1 0 00 0 00
drain_b      pop    1 00 00  1 1 b1 0 00
full_push_0  push   3 10 00  1 0 00 0 00
full_push_1  push   3 21 00  1 0 00 0 00
full_push_2  push   1 32 00  1 0 00 0 00
full_push_3  push   1 43 00  1 0 00 0 00
full_push_4  push   0 54 00  1 0 00 0 00
full_push_5  push   2 65 00  1 0 00 0 00
full_push_6  push   3 76 00  1 0 00 0 00
full_push_7  push   1 87 00  1 0 00 0 00
full_gnt     idle   0 00 00  0 0 00 0 00
full_push    push   2 ee 00  0 0 00 0 00
full_read    read   3 00 00  1 1 10 0 00
full_pop     pop    3 00 00  1 1 10 0 00
full_regnt   idle   0 00 00  1 0 00 0 00
prio_both    both   2 99 00  0 0 00 0 00
prio_full    idle   0 00 00  0 0 00 0 00
prio_pop_a   pop    2 00 00  1 1 65 0 00
prio_pop_b   pop    2 00 00  1 1 99 0 00
ex_odd       exists 0 01 01  1 0 00 1 21
ex_push      push   0 c3 00  1 0 00 0 00
ex_odd_new   exists 0 01 01  1 0 00 1 c3
ex_nibble    exists 0 40 f0  1 0 00 1 43
ex_absent    exists 0 ee ff  1 0 00 0 00
ex_pop       pop    0 00 00  1 1 54 0 00
ex_freed     exists 0 54 ff  1 0 00 0 00
ex_pop_last  pop    0 00 00  1 1 c3 0 00
ex_lowest    exists 0 01 01  1 0 00 1 21
done         end    0 00 00  0 0 00 0 00

// ==== filelist.f ====
+incdir+source
source/id_queue_pkg.sv
source/lzc.sv
source/head_tail_table.sv
source/linked_data_store.sv
source/queue_control.sv
source/id_queue.sv
test/tb_id_queue.sv

// ==== Bender.yml ====
package:
  name: id_queue

sources:
  - include_dirs:
      - source
    files:
      - source/id_queue_pkg.sv
      - source/lzc.sv
      - source/head_tail_table.sv
      - source/linked_data_store.sv
      - source/queue_control.sv
      - source/id_queue.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_id_queue.sv
